//--- compile.f
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/hazardUnit.sv
verilog/pipeReg.sv
verilog/mipsCore.sv
verif/tbMipsCore.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- verif/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;
    import mipsPkg::*;

    localparam dataT ResetPc       = 32'h0000_0100;
    localparam int   TimeoutCycles = 2000;
    localparam int   DrainCycles   = 20;

    logic   clk;
    logic   rst;
    dataT   instr;
    dataT   memRdata;
    dataT   pc;
    dataT   memAddr;
    dataT   memWdata;
    logic   memWen;
    logic   memRead;
    dataT   debugWbPc;
    logic   debugWbRfWen;
    regIdxT debugWbRfWnum;
    dataT   debugWbRfWdata;

    dataT        imem [256];
    dataT        dmem [256];
    logic [31:0] lfsrState;
    int          progLen;
    int          errors;
    int          checks;
    int          wrIdx;
    int          stIdx;
    int          ldIdx;
    logic        seenCommit;

    // expected register writes, stores and loads in program order
    dataT   expWrPc[$];
    regIdxT expWrNum[$];
    dataT   expWrData[$];
    dataT   expStAddr[$];
    dataT   expStData[$];
    dataT   expLdAddr[$];

    mipsCore #(.ResetPc(ResetPc)) i_dut (
        .clk(clk), .rst(rst), .instr(instr), .memRdata(memRdata), .pc(pc),
        .memAddr(memAddr), .memWdata(memWdata), .memWen(memWen), .memRead(memRead),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    always #10 clk = ~clk;

    assign instr    = imem[pc[9:2]];
    assign memRdata = dmem[memAddr[9:2]];

    function automatic dataT fillWord(logic [7:0] idx);
        return {8'ha5, idx, ~idx, idx ^ 8'h3c};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i[7:0]);
            end
        end else if (memWen) begin
            dmem[memAddr[9:2]] <= memWdata;
        end
    end

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic dataT takeBits(int n);
        dataT v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic dataT rType(logic [5:0] fn, regIdxT rd, regIdxT rs, regIdxT rt);
        return {OpRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic dataT iType(logic [5:0] op, regIdxT rt, regIdxT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void putInstr(dataT w);
        imem[ResetPc[9:2] + progLen[7:0]] = w;
        progLen++;
    endfunction

    function automatic void buildProgram();
        logic [5:0] fnTab [5];
        logic [5:0] opTab [3];
        dataT       sel;
        dataT       rd;
        dataT       rs;
        dataT       rt;
        dataT       imm;
        fnTab = '{FnAddu, FnSubu, FnAnd, FnOr, FnSlt};
        opTab = '{OpAddiu, OpOri, OpLui};
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0; // nop
        end
        progLen   = 0;
        lfsrState = 32'hd073;
        putInstr(iType(OpAddiu, 5'd1, 5'd0, 16'h0010));
        putInstr(iType(OpAddiu, 5'd2, 5'd1, 16'h0005)); // forward from memory
        putInstr(rType(FnAddu, 5'd3, 5'd1, 5'd2));
        putInstr(iType(OpLui, 5'd4, 5'd0, 16'h1234));
        putInstr(iType(OpOri, 5'd4, 5'd4, 16'h8678));   // zero extended
        putInstr(rType(FnSubu, 5'd5, 5'd4, 5'd3));
        putInstr(iType(OpAddiu, 5'd19, 5'd0, 16'hfff0));
        putInstr(rType(FnSlt, 5'd6, 5'd19, 5'd1));      // signed compare
        putInstr(rType(FnAnd, 5'd7, 5'd4, 5'd5));
        putInstr(rType(FnOr, 5'd8, 5'd7, 5'd6));
        putInstr(iType(OpAddiu, 5'd9, 5'd0, 16'h0040));
        putInstr(iType(OpSw, 5'd5, 5'd9, 16'h0004));
        putInstr(iType(OpLw, 5'd10, 5'd9, 16'h0004));
        putInstr(rType(FnAddu, 5'd11, 5'd10, 5'd1));    // load-use
        putInstr(iType(OpLw, 5'd12, 5'd9, 16'h0008));
        putInstr(rType(FnOr, 5'd13, 5'd12, 5'd0));
        putInstr(iType(OpBeq, 5'd1, 5'd1, 16'h0002));   // taken
        putInstr(iType(OpAddiu, 5'd14, 5'd0, 16'h0001));
        putInstr(iType(OpAddiu, 5'd15, 5'd0, 16'h0002));
        putInstr(iType(OpAddiu, 5'd16, 5'd0, 16'h0003));
        putInstr(iType(OpBeq, 5'd2, 5'd1, 16'h0001));   // not taken
        putInstr(iType(OpAddiu, 5'd17, 5'd0, 16'h0004));
        putInstr(iType(OpAddiu, 5'd0, 5'd1, 16'h0007));
        putInstr(rType(FnAddu, 5'd0, 5'd1, 5'd2));
        putInstr(rType(FnAddu, 5'd18, 5'd0, 5'd1));
        putInstr(iType(OpSw, 5'd18, 5'd9, 16'h0000));
        // random alu block on registers 0..15
        for (int n = 0; n < 40; n++) begin
            sel = takeBits(3);
            rd  = takeBits(4);
            rs  = takeBits(4);
            rt  = takeBits(4);
            imm = takeBits(16);
            if (sel < 5) begin
                putInstr(rType(fnTab[sel], rd[4:0], rs[4:0], rt[4:0]));
            end else begin
                putInstr(iType(opTab[sel - 5], rt[4:0], rs[4:0], imm[15:0]));
            end
        end
    endfunction

    // instruction-level model without a pipeline
    function automatic void runModel();
        dataT   regsM [32];
        dataT   memM [256];
        dataT   pcM;
        dataT   curPc;
        dataT   w;
        dataT   ra;
        dataT   rb;
        dataT   simm;
        dataT   addr;
        dataT   val;
        regIdxT wn;
        logic   wr;
        int     steps;
        for (int i = 0; i < 32; i++) begin
            regsM[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            memM[i] = fillWord(i[7:0]);
        end
        pcM   = ResetPc;
        steps = 0;
        while (pcM < ResetPc + 32'(4 * progLen) && steps < 1000) begin
            curPc = pcM;
            w     = imem[pcM[9:2]];
            ra    = regsM[w[25:21]];
            rb    = regsM[w[20:16]];
            simm  = {{16{w[15]}}, w[15:0]};
            addr  = ra + simm;
            wr    = 1'b1;
            wn    = w[20:16];
            val   = '0;
            pcM   = pcM + 32'd4;
            case (w[31:26])
                OpRtype: begin
                    wn = w[15:11];
                    case (w[5:0])
                        FnAddu:  val = ra + rb;
                        FnSubu:  val = ra - rb;
                        FnAnd:   val = ra & rb;
                        FnOr:    val = ra | rb;
                        FnSlt:   val = ($signed(ra) < $signed(rb)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OpAddiu: val = addr;
                OpOri:   val = ra | {16'h0000, w[15:0]};
                OpLui:   val = {w[15:0], 16'h0000};
                OpLw: begin
                    val = memM[addr[9:2]];
                    expLdAddr.push_back(addr);
                end
                OpSw: begin
                    wr = 1'b0;
                    memM[addr[9:2]] = rb;
                    expStAddr.push_back(addr);
                    expStData.push_back(rb);
                end
                OpBeq: begin
                    wr = 1'b0;
                    if (ra == rb) begin
                        pcM = pcM + {simm[29:0], 2'b00};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && wn != 5'd0) begin
                regsM[wn] = val;
                expWrPc.push_back(curPc);
                expWrNum.push_back(wn);
                expWrData.push_back(val);
            end
            steps++;
        end
    endfunction

    task automatic checkValue(input string name, input dataT expected, input dataT actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!seenCommit) begin
                checks++;
                assert (!memWen && !memRead) else begin
                    errors++;
                    $display("memory port active before the first commit");
                end
            end
            if (debugWbRfWen) begin
                if (wrIdx < expWrPc.size()) begin
                    checkValue("commit pc", expWrPc[wrIdx], debugWbPc);
                    checkValue("commit reg", {27'd0, expWrNum[wrIdx]}, {27'd0, debugWbRfWnum});
                    checkValue("commit data", expWrData[wrIdx], debugWbRfWdata);
                end else begin
                    errors++;
                    $display("unexpected commit from pc %h to reg %0d", debugWbPc, debugWbRfWnum);
                end
                wrIdx++;
                seenCommit = 1'b1;
            end
            if (memWen) begin
                if (stIdx < expStAddr.size()) begin
                    checkValue("store addr", expStAddr[stIdx], memAddr);
                    checkValue("store data", expStData[stIdx], memWdata);
                end else begin
                    errors++;
                    $display("unexpected store to address %h", memAddr);
                end
                stIdx++;
            end
            if (memRead) begin
                if (ldIdx < expLdAddr.size()) begin
                    checkValue("load addr", expLdAddr[ldIdx], memAddr);
                end else begin
                    errors++;
                    $display("unexpected load from address %h", memAddr);
                end
                ldIdx++;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        errors     = 0;
        checks     = 0;
        wrIdx      = 0;
        stIdx      = 0;
        ldIdx      = 0;
        seenCommit = 1'b0;
        buildProgram();
        runModel();
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        for (int cyc = 0; cyc < TimeoutCycles; cyc++) begin
            if (wrIdx >= expWrPc.size() && stIdx >= expStAddr.size()
                    && ldIdx >= expLdAddr.size()) begin
                break;
            end
            @(posedge clk);
        end
        if (wrIdx < expWrPc.size() || stIdx < expStAddr.size() || ldIdx < expLdAddr.size()) begin
            errors++;
            $display("timeout: saw %0d of %0d writes, %0d of %0d stores, %0d of %0d loads",
                     wrIdx, expWrPc.size(), stIdx, expStAddr.size(),
                     ldIdx, expLdAddr.size());
        end
        for (int cyc = 0; cyc < DrainCycles; cyc++) begin
            @(posedge clk); // catch stray commits
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter mipsPkg::dataT ResetPc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::dataT   instr,
    input  mipsPkg::dataT   memRdata,
    output mipsPkg::dataT   pc,
    output mipsPkg::dataT   memAddr,
    output mipsPkg::dataT   memWdata,
    output logic            memWen,
    output logic            memRead,
    output mipsPkg::dataT   debugWbPc,
    output logic            debugWbRfWen,
    output mipsPkg::regIdxT debugWbRfWnum,
    output mipsPkg::dataT   debugWbRfWdata
);
    import mipsPkg::*;

    dataT    pcPlus4F;
    dataT    pcNext;
    logic    stallF;
    logic    stallD;
    logic    flushD;
    logic    flushE;
    ifIdT    ifIdIn;
    ifIdT    ifIdQ;
    regIdxT  rsD;
    regIdxT  rtD;
    regIdxT  destD;
    dataT    immD;
    aluOpT   aluOpD;
    logic    regWriteD;
    logic    memReadD;
    logic    memWriteD;
    logic    aluImmD;
    logic    branchD;
    dataT    rsValD;
    dataT    rtValD;
    idExT    idExIn;
    idExT    idExQ;
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    dataT    opAE;
    dataT    opBE;
    dataT    srcBE;
    dataT    aluResultE;
    logic    equalE;
    logic    branchTakenE;
    dataT    branchTargetE;
    exMemT   exMemIn;
    exMemT   exMemQ;
    dataT    resultM;
    memWbT   memWbIn;
    memWbT   memWbQ;

    // fetch
    assign pcPlus4F = pc + 32'd4;
    assign pcNext   = branchTakenE ? branchTargetE : pcPlus4F;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end

    assign ifIdIn = '{instr: instr, pc: pc};

    pipeReg #(.payloadT(ifIdT)) ifIdReg0 (
        .clk(clk), .rst(rst), .stall(stallD), .flush(flushD), .d(ifIdIn), .q(ifIdQ)
    );

    // decode
    instrDecoder instrDecoder0 (
        .instr(ifIdQ.instr), .rs(rsD), .rt(rtD), .dest(destD), .imm(immD), .aluOp(aluOpD),
        .regWrite(regWriteD), .memRead(memReadD), .memWrite(memWriteD),
        .aluImm(aluImmD), .branch(branchD)
    );

    regFile regFile0 (
        .clk(clk), .rst(rst), .raddrA(rsD), .raddrB(rtD),
        .waddr(memWbQ.dest), .wdata(memWbQ.result), .wen(memWbQ.regWrite),
        .rdataA(rsValD), .rdataB(rtValD)
    );

    assign idExIn = '{pc: ifIdQ.pc, rsVal: rsValD, rtVal: rtValD, imm: immD,
                      rs: rsD, rt: rtD, dest: destD, aluOp: aluOpD,
                      regWrite: regWriteD, memRead: memReadD, memWrite: memWriteD,
                      aluImm: aluImmD, branch: branchD};

    pipeReg #(.payloadT(idExT)) idExReg0 (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flushE), .d(idExIn), .q(idExQ)
    );

    // execute
    function automatic dataT fwdMux(fwdSelT sel, dataT regVal);
        case (sel)
            FwdMem:  return exMemQ.aluOut;
            FwdWb:   return memWbQ.result;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opAE = fwdMux(fwdA, idExQ.rsVal);
        opBE = fwdMux(fwdB, idExQ.rtVal);
    end

    assign srcBE = idExQ.aluImm ? idExQ.imm : opBE;

    alu alu0 (.a(opAE), .b(srcBE), .op(idExQ.aluOp), .result(aluResultE), .equal(equalE));

    assign branchTakenE  = idExQ.branch && equalE; // predicted not taken
    assign branchTargetE = idExQ.pc + 32'd4 + {idExQ.imm[29:0], 2'b00};

    hazardUnit hazardUnit0 (
        .clk(clk), .rst(rst), .rsD(rsD), .rtD(rtD), .rsE(idExQ.rs), .rtE(idExQ.rt),
        .destE(idExQ.dest), .destM(exMemQ.dest), .destW(memWbQ.dest),
        .memReadE(idExQ.memRead), .regWriteM(exMemQ.regWrite), .regWriteW(memWbQ.regWrite),
        .branchTakenE(branchTakenE), .fwdA(fwdA), .fwdB(fwdB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    assign exMemIn = '{pc: idExQ.pc, aluOut: aluResultE, storeData: opBE, dest: idExQ.dest,
                       regWrite: idExQ.regWrite, memRead: idExQ.memRead,
                       memWrite: idExQ.memWrite};

    pipeReg #(.payloadT(exMemT)) exMemReg0 (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(exMemIn), .q(exMemQ)
    );

    // memory
    assign memAddr  = exMemQ.aluOut;
    assign memWdata = exMemQ.storeData;
    assign memWen   = exMemQ.memWrite;
    assign memRead  = exMemQ.memRead;
    assign resultM  = exMemQ.memRead ? memRdata : exMemQ.aluOut;

    assign memWbIn = '{pc: exMemQ.pc, result: resultM, dest: exMemQ.dest,
                       regWrite: exMemQ.regWrite};

    pipeReg #(.payloadT(memWbT)) memWbReg0 (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(memWbIn), .q(memWbQ)
    );

    // writeback trace
    assign debugWbPc      = memWbQ.pc;
    assign debugWbRfWen   = memWbQ.regWrite && (memWbQ.dest != '0);
    assign debugWbRfWnum  = memWbQ.dest;
    assign debugWbRfWdata = memWbQ.result;

    pcWordAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // flush beats stall, a cleared payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::regIdxT rsD,
    input  mipsPkg::regIdxT rtD,
    input  mipsPkg::regIdxT rsE,
    input  mipsPkg::regIdxT rtE,
    input  mipsPkg::regIdxT destE,
    input  mipsPkg::regIdxT destM,
    input  mipsPkg::regIdxT destW,
    input  logic            memReadE,
    input  logic            regWriteM,
    input  logic            regWriteW,
    input  logic            branchTakenE,
    output mipsPkg::fwdSelT fwdA,
    output mipsPkg::fwdSelT fwdB,
    output logic            stallF,
    output logic            stallD,
    output logic            flushD,
    output logic            flushE
);
    import mipsPkg::*;

    logic loadUse;

    // memory stage is younger, so it wins over writeback
    function automatic fwdSelT pickFwd(regIdxT src);
        if (regWriteM && destM != '0 && destM == src) return FwdMem;
        if (regWriteW && destW != '0 && destW == src) return FwdWb;
        return FwdReg;
    endfunction

    always_comb begin
        fwdA = pickFwd(rsE);
        fwdB = pickFwd(rtE);
    end

    assign loadUse = memReadE && destE != '0 && (destE == rsD || destE == rtD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = branchTakenE;            // drop the two younger instructions
    assign flushE = loadUse || branchTakenE; // bubble on load-use

    noStallOnBranchFlush: assert property (@(posedge clk) disable iff (rst)
        !(stallD && flushD));

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mipsPkg::dataT  a,
    input  mipsPkg::dataT  b,
    input  mipsPkg::aluOpT op,
    output mipsPkg::dataT  result,
    output logic           equal
);
    import mipsPkg::*;

    logic lessSigned;

    assign lessSigned = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluSlt:  result = {31'b0, lessSigned};
            AluLui:  result = {b[15:0], 16'h0000}; // imm into upper half
            default: result = '0;
        endcase
    end

    // beq compares the forwarded rs and rt values
    assign equal = (a == b);

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::regIdxT raddrA,
    input  mipsPkg::regIdxT raddrB,
    input  mipsPkg::regIdxT waddr,
    input  mipsPkg::dataT   wdata,
    input  logic            wen,
    output mipsPkg::dataT   rdataA,
    output mipsPkg::dataT   rdataB
);
    import mipsPkg::*;

    dataT regs [32];
    logic wrLive;

    assign wrLive = wen && (waddr != '0); // $0 is never written

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the writeback value in the same cycle
    assign rdataA = (wrLive && waddr == raddrA) ? wdata : regs[raddrA];
    assign rdataB = (wrLive && waddr == raddrB) ? wdata : regs[raddrB];

    zeroRegReadsZero: assert property (@(posedge clk) disable iff (rst)
        (raddrA != '0 || rdataA == '0) && (raddrB != '0 || rdataB == '0));

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  mipsPkg::dataT   instr,
    output mipsPkg::regIdxT rs,
    output mipsPkg::regIdxT rt,
    output mipsPkg::regIdxT dest,
    output mipsPkg::dataT   imm,
    output mipsPkg::aluOpT  aluOp,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            aluImm,
    output logic            branch
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    always_comb begin
        dest     = instr[20:16];                     // immediate forms write rt
        imm      = {{16{instr[15]}}, instr[15:0]};
        aluOp    = AluAdd;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluImm   = 1'b0;
        branch   = 1'b0;
        case (opcode)
            OpRtype: begin
                dest     = instr[15:11];
                regWrite = 1'b1;
                case (funct)
                    FnAddu:  aluOp = AluAdd;
                    FnSubu:  aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnSlt:   aluOp = AluSlt;
                    default: regWrite = 1'b0;        // unknown funct, treat as nop
                endcase
            end
            OpAddiu: begin
                regWrite = 1'b1;
                aluImm   = 1'b1;
            end
            OpOri: begin
                imm      = {16'h0000, instr[15:0]};
                aluOp    = AluOr;
                regWrite = 1'b1;
                aluImm   = 1'b1;
            end
            OpLui: begin
                imm      = {16'h0000, instr[15:0]};
                aluOp    = AluLui;
                regWrite = 1'b1;
                aluImm   = 1'b1;
            end
            OpLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                aluImm   = 1'b1;
            end
            OpSw: begin
                memWrite = 1'b1;
                aluImm   = 1'b1;
            end
            OpBeq: begin
                aluOp  = AluSub;
                branch = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] dataT;
    typedef logic [4:0]  regIdxT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluLui
    } aluOpT;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FwdReg,
        FwdMem,
        FwdWb
    } fwdSelT;

    localparam logic [5:0] OpRtype = 6'h00;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpOri   = 6'h0d;
    localparam logic [5:0] OpLui   = 6'h0f;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;

    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef struct packed {
        dataT instr;
        dataT pc;
    } ifIdT;

    typedef struct packed {
        dataT   pc;
        dataT   rsVal;
        dataT   rtVal;
        dataT   imm;
        regIdxT rs;
        regIdxT rt;
        regIdxT dest;
        aluOpT  aluOp;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluImm;
        logic   branch;
    } idExT;

    typedef struct packed {
        dataT   pc;
        dataT   aluOut;
        dataT   storeData;
        regIdxT dest;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
    } exMemT;

    typedef struct packed {
        dataT   pc;
        dataT   result; // load data or alu result
        regIdxT dest;
        logic   regWrite;
    } memWbT;

endpackage

`default_nettype wire
